/* verif/shared_mem_tests.txt */
# req stall flush gnt | we0 a0 d0 | we1 a1 d1 | we2 a2 d2 | we3 a3 d3
# masks hold one bit per port with port 0 in bit 0, every field is hex
# write then read back, lone requests win whatever the priority
1 0 0 1  0 05 0000  0 00 0000  0 00 0000  0 00 0000
1 0 0 1  1 05 a5a5  0 00 0000  0 00 0000  0 00 0000
2 0 0 2  0 00 0000  0 05 0000  0 00 0000  0 00 0000
0 0 0 0  0 00 0000  0 00 0000  0 00 0000  0 00 0000
8 0 0 8  0 00 0000  0 00 0000  0 00 0000  1 3f beef
4 0 0 4  0 00 0000  0 00 0000  0 3f 0000  0 00 0000
0 0 0 0  0 00 0000  0 00 0000  0 00 0000  0 00 0000
# flush, then all four ports rotate 0 1 2 3 0
0 0 1 0  0 00 0000  0 00 0000  0 00 0000  0 00 0000
f 0 0 1  0 05 0000  0 10 0000  0 3f 0000  0 20 0000
f 0 0 2  0 05 0000  0 10 0000  0 3f 0000  0 20 0000
f 0 0 4  0 05 0000  0 10 0000  0 3f 0000  0 20 0000
f 0 0 8  0 05 0000  0 10 0000  0 3f 0000  0 20 0000
f 0 0 1  0 05 0000  0 10 0000  0 3f 0000  0 20 0000
# ports 1 and 3 alternate
a 0 0 2  0 00 0000  0 05 0000  0 00 0000  0 3f 0000
a 0 0 8  0 00 0000  0 05 0000  0 00 0000  0 3f 0000
a 0 0 2  0 00 0000  0 05 0000  0 00 0000  0 3f 0000
a 0 0 8  0 00 0000  0 05 0000  0 00 0000  0 3f 0000
0 0 0 0  0 00 0000  0 00 0000  0 00 0000  0 00 0000
# stall locks port 0 in, port 1 joins with the higher priority and waits
1 1 0 0  1 07 1234  0 00 0000  0 00 0000  0 00 0000
3 1 0 0  1 07 1234  0 07 0000  0 00 0000  0 00 0000
3 0 0 1  1 07 1234  0 07 0000  0 00 0000  0 00 0000
2 0 0 2  0 00 0000  0 07 0000  0 00 0000  0 00 0000
0 0 0 0  0 00 0000  0 00 0000  0 00 0000  0 00 0000
4 0 0 4  0 00 0000  0 00 0000  0 05 0000  0 00 0000
# flush moves the priority back to port 0
0 0 1 0  0 00 0000  0 00 0000  0 00 0000  0 00 0000
f 0 0 1  0 00 0000  0 3f 0000  0 07 0000  0 10 0000
e 0 0 2  0 00 0000  0 3f 0000  0 07 0000  0 10 0000
0 0 0 0  0 00 0000  0 00 0000  0 00 0000  0 00 0000

/* src.f */
+incdir+include
rtl/arb_pkg.sv
rtl/lzc.sv
rtl/rr_arb_tree.sv
rtl/sram_bank.sv
rtl/rsp_router.sv
rtl/shared_mem_top.sv
verif/tb_clk_gen.sv
verif/tb_shared_mem.sv

/* run_sim.sh */
#!/bin/sh
# build the shared memory arbiter testbench with Verilator and run it,
# the run passes only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f src.f --top-module tb_shared_mem -o tb_shared_mem \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_shared_mem > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "^Simulation completed successfully$" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

/* verif/tb_shared_mem.sv */
////////////////////
// testbench for the shared memory port arbiter
// replays per cycle stimulus from a data file against a reference model
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "arb_settings.svh"

module tb_shared_mem;

  localparam int unsigned NumPorts  = `ARB_NUM_PORTS;
  localparam int unsigned Depth     = 2**`ARB_ADDR_W;
  localparam int unsigned MaxSteps  = 128;
  localparam int unsigned WaitLimit = 16;

  // one line of the data file holds the stimulus and the expected grant
  typedef struct packed {
    logic [NumPorts-1:0]              req;
    logic                             stall;
    logic                             flush;
    logic [NumPorts-1:0]              gnt;
    arb_pkg::mem_req_t [NumPorts-1:0] ports;
  } step_t;

  logic                             clk;
  logic                             rst_n;
  logic                             flush;
  logic                             stall;
  logic [NumPorts-1:0]              req;
  arb_pkg::mem_req_t [NumPorts-1:0] port_req;
  logic [NumPorts-1:0]              gnt;
  logic [NumPorts-1:0]              rsp_valid;
  logic [`ARB_DATA_W-1:0]           rsp_rdata;

  step_t steps [MaxSteps];
  int    num_steps;

  // the reference model keeps a priority pointer, a lock with its frozen vector and a shadow memory
  int                     m_prio;
  logic                   m_lock;
  logic [NumPorts-1:0]    m_frozen;
  logic [`ARB_DATA_W-1:0] shadow [Depth];
  logic                   pend_valid;
  int                     pend_port;
  logic [`ARB_DATA_W-1:0] pend_data;

  tb_clk_gen #(.Period(4), .RstCycles(3)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  shared_mem_top UUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .flush_i     (flush),
    .stall_i     (stall),
    .req_i       (req),
    .port_req_i  (port_req),
    .gnt_o       (gnt),
    .rsp_valid_o (rsp_valid),
    .rsp_rdata_o (rsp_rdata)
  );

  ////////////////////
  // reporting
  ////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // walk down from the root where a half wins alone if only it requests
  // and otherwise the priority bit of that level chooses
  function automatic int pick_port(input logic [NumPorts-1:0] r, input int prio);
    int   lo;
    int   span;
    int   lvl;
    int   i;
    logic low_any;
    logic high_any;
    lo   = 0;
    span = NumPorts;
    lvl  = $clog2(NumPorts) - 1;
    while (span > 1) begin
      span     = span / 2;
      low_any  = 1'b0;
      high_any = 1'b0;
      for (i = 0; i < span; i++) begin
        low_any  = low_any | r[lo+i];
        high_any = high_any | r[lo+span+i];
      end
      if (high_any && (!low_any || ((prio >> lvl) & 1) == 1)) begin
        lo = lo + span;
      end
      lvl = lvl - 1;
    end
    return lo;
  endfunction

  // the fair rule takes the first requester above the winner and else wraps to the lowest one
  function automatic int next_priority(input logic [NumPorts-1:0] r, input int win);
    int i;
    for (i = win + 1; i < NumPorts; i++) begin
      if (r[i]) return i;
    end
    for (i = 0; i <= win; i++) begin
      if (r[i]) return i;
    end
    return win;
  endfunction

  // this runs in the middle of a cycle to check the outputs and then advance the model
  task automatic check_cycle(input step_t s);
    logic [NumPorts-1:0] eff;
    logic [NumPorts-1:0] exp_gnt;
    logic [NumPorts-1:0] exp_valid;
    logic                accept;
    int                  win;
    arb_pkg::mem_req_t   w;
    eff       = m_lock ? m_frozen : s.req;
    accept    = (|eff) && !s.stall;
    win       = pick_port(eff, m_prio);
    exp_gnt   = accept ? (NumPorts'(1) << win) : '0;
    exp_valid = pend_valid ? (NumPorts'(1) << pend_port) : '0;
    check_value("gnt_o", 32'(gnt), 32'(exp_gnt));
    check_value("gnt_o against data file", 32'(gnt), 32'(s.gnt));
    check_value("rsp_valid_o", 32'(rsp_valid), 32'(exp_valid));
    if (pend_valid) begin
      check_value("rsp_rdata_o", 32'(rsp_rdata), 32'(pend_data));
    end
    // the bank answers in the next cycle with the word as it was before a write
    pend_valid = accept;
    if (accept) begin
      w         = s.ports[win];
      pend_port = win;
      pend_data = shadow[w.addr];
      if (w.we) shadow[w.addr] = w.wdata;
    end
    if (s.flush) begin
      m_prio   = 0;
      m_lock   = 1'b0;
      m_frozen = '0;
    end else begin
      if (accept) m_prio = next_priority(eff, win);
      m_lock   = (|eff) && s.stall;
      m_frozen = eff;
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic load_tests();
    int          fd;
    int          n;
    int          p;
    string       line;
    logic [31:0] f [16];
    step_t       s;
    fd = $fopen("verif/shared_mem_tests.txt", "r");
    if (fd == 0) report_failure("could not open the test data file");
    num_steps = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // blank lines and lines starting with # carry no stimulus
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                  f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
      if (n != 16) report_failure("a line of the test data file does not hold 16 fields");
      if (num_steps >= MaxSteps) report_failure("the test data file has too many lines");
      s.req   = f[0][NumPorts-1:0];
      s.stall = f[1][0];
      s.flush = f[2][0];
      s.gnt   = f[3][NumPorts-1:0];
      for (p = 0; p < NumPorts; p++) begin
        s.ports[p].we    = f[4+3*p][0];
        s.ports[p].addr  = f[5+3*p][`ARB_ADDR_W-1:0];
        s.ports[p].wdata = f[6+3*p][`ARB_DATA_W-1:0];
      end
      steps[num_steps] = s;
      num_steps++;
    end
    $fclose(fd);
  endtask

  task automatic drive_step(input step_t s);
    @(posedge clk);
    req      <= s.req;
    stall    <= s.stall;
    flush    <= s.flush;
    port_req <= s.ports;
    @(negedge clk);
    check_cycle(s);
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) report_failure("reset was not released in time");
  endtask

  // the answer to a last accepted request comes one idle cycle later and is checked there
  task automatic drain_responses();
    step_t idle;
    idle = '0;
    if (pend_valid) begin
      drive_step(idle);
    end
  endtask

  initial begin
    int i;
    $timeformat(-9, 1, " ns", 0);
    req        = '0;
    stall      = 1'b0;
    flush      = 1'b0;
    port_req   = '0;
    m_prio     = 0;
    m_lock     = 1'b0;
    m_frozen   = '0;
    pend_valid = 1'b0;
    pend_port  = 0;
    pend_data  = '0;
    // the bank is all zero after reset
    for (i = 0; i < Depth; i++) shadow[i] = '0;
    load_tests();
    wait_reset();
    for (i = 0; i < num_steps; i++) drive_step(steps[i]);
    drain_responses();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
////////////////////
// testbench clock and reset source
////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned Period    = 4,
  parameter int unsigned RstCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // reset is released on a rising edge, so the flops still see it low at that edge
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

/* rtl/shared_mem_top.sv */
////////////////////
// shared memory port arbiter, top level
// four clients share one memory bank through a round robin tree,
// responses return one cycle after the grant
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "arb_settings.svh"

module shared_mem_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   stall_i,
  input  logic              [`ARB_NUM_PORTS-1:0] req_i,
  input  arb_pkg::mem_req_t [`ARB_NUM_PORTS-1:0] port_req_i,
  output logic              [`ARB_NUM_PORTS-1:0] gnt_o,
  output logic              [`ARB_NUM_PORTS-1:0] rsp_valid_o,
  output logic              [`ARB_DATA_W-1:0]    rsp_rdata_o
);

  logic               arb_req;
  arb_pkg::mem_req_t  arb_data;
  arb_pkg::port_idx_t arb_idx;
  arb_pkg::mem_rsp_t  bank_rsp;
  logic               accept;

  // a request is taken in every cycle that has a winner and no stall
  assign accept = arb_req & ~stall_i;

  // the bank is ready exactly when it is not stalled
  rr_arb_tree #(
    .NumIn   (`ARB_NUM_PORTS),
    .FairArb (`ARB_FAIR)
  ) i_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .req_i   (req_i),
    .data_i  (port_req_i),
    .gnt_o   (gnt_o),
    .req_o   (arb_req),
    .gnt_i   (~stall_i),
    .data_o  (arb_data),
    .idx_o   (arb_idx)
  );

  sram_bank i_bank (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (arb_req),
    .req_i       (arb_data),
    .accept_i    (accept),
    .rsp_o       (bank_rsp)
  );

  // the router tracks which port the read data belongs to
  rsp_router i_router (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .accept_i    (accept),
    .idx_i       (arb_idx),
    .rsp_valid_o (rsp_valid_o)
  );

  // read data is broadcast, each port qualifies it with its own valid
  assign rsp_rdata_o = bank_rsp.rdata;

endmodule

`default_nettype wire

/* rtl/rsp_router.sv */
////////////////////
// response router
// pulses the valid of the port that won one cycle earlier
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "arb_settings.svh"

module rsp_router (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       accept_i,
  input  arb_pkg::port_idx_t         idx_i,
  output logic [`ARB_NUM_PORTS-1:0]  rsp_valid_o
);

  logic               acc_q;
  arb_pkg::port_idx_t idx_q;

  // the accept strobe lines up with the bank read data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= 1'b0;
    end else begin
      acc_q <= accept_i;
    end
  end

  // winner index, only meaningful while acc_q is high
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      idx_q <= idx_i;
    end
  end

  // one hot decode, at most one port sees a response per cycle
  always_comb begin
    rsp_valid_o = '0;
    if (acc_q) begin
      rsp_valid_o[idx_q] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/sram_bank.sv */
////////////////////
// single port memory bank
// read before write, read data appears one cycle after the accept
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "arb_settings.svh"

module sram_bank (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  input  arb_pkg::mem_req_t  req_i,
  input  logic               accept_i,
  output arb_pkg::mem_rsp_t  rsp_o
);

  localparam int unsigned depth = 2**`ARB_ADDR_W;

  logic [`ARB_DATA_W-1:0] mem_q [depth];
  logic [`ARB_DATA_W-1:0] rdata_q;
  logic                   access;

  // the bank only moves on a valid request that the arbiter handed over
  assign access = req_valid_i & accept_i;

  // the whole array starts out zero so a read of an unwritten word is defined
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < depth; i++) begin
        mem_q[i] <= '0;
      end
      rdata_q <= '0;
    end else if (access) begin
      // the old word is captured even on a write
      rdata_q <= mem_q[req_i.addr];
      if (req_i.we) begin
        mem_q[req_i.addr] <= req_i.wdata;
      end
    end
  end

  assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

/* rtl/rr_arb_tree.sv */
////////////////////
// round robin arbitration tree
// picks one request per cycle through a binary tree of select nodes,
// holds the decision while the output stalls and muxes the winning payload
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "arb_settings.svh"

module rr_arb_tree #(
  parameter int unsigned NumIn   = `ARB_NUM_PORTS,
  parameter bit          FairArb = `ARB_FAIR
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  input  logic              [NumIn-1:0]      req_i,
  input  arb_pkg::mem_req_t [NumIn-1:0]      data_i,
  output logic              [NumIn-1:0]      gnt_o,
  output logic                               req_o,
  input  logic                               gnt_i,
  output arb_pkg::mem_req_t                  data_o,
  output arb_pkg::port_idx_t                 idx_o
);

  localparam int unsigned num_levels = $clog2(NumIn);
  localparam int unsigned num_nodes  = 2**num_levels - 1;

  // tree nodes, node 0 is the root and the leaves face the inputs
  arb_pkg::port_idx_t [num_nodes-1:0] idx_nodes;
  arb_pkg::mem_req_t  [num_nodes-1:0] data_nodes;
  logic               [num_nodes-1:0] gnt_nodes;
  logic               [num_nodes-1:0] req_nodes;

  // rr_q names the port with the highest priority in the current cycle
  arb_pkg::port_idx_t rr_q;
  arb_pkg::port_idx_t rr_d;
  logic               lock_q;
  logic               lock_d;
  logic [NumIn-1:0]   req_q;
  logic [NumIn-1:0]   req_d;
  logic               accept;

  ////////////////////
  // lock and priority state
  ////////////////////

  // a request that is presented but not taken locks the sampled vector,
  // so a stall cannot change which port wins
  assign lock_d = req_o & ~gnt_i;
  assign req_d  = lock_q ? req_q : req_i;
  assign accept = req_o & gnt_i;

  if (FairArb) begin : gen_fair
    logic [NumIn-1:0]   upper_mask;
    logic [NumIn-1:0]   lower_mask;
    arb_pkg::port_idx_t upper_idx;
    arb_pkg::port_idx_t lower_idx;
    arb_pkg::port_idx_t next_idx;
    logic               upper_empty;
    logic               lower_empty;

    // split the requests into those above the winner and those at or below it
    for (genvar i = 0; i < NumIn; i++) begin : gen_mask
      assign upper_mask[i] = (i >  int'(idx_o)) ? req_d[i] : 1'b0;
      assign lower_mask[i] = (i <= int'(idx_o)) ? req_d[i] : 1'b0;
    end

    lzc #(
      .WIDTH   (NumIn)
    ) i_lzc_upper (
      .in_i    (upper_mask),
      .cnt_o   (upper_idx),
      .empty_o (upper_empty)
    );

    lzc #(
      .WIDTH   (NumIn)
    ) i_lzc_lower (
      .in_i    (lower_mask),
      .cnt_o   (lower_idx),
      .empty_o (lower_empty)
    );

    // the next port above the winner goes first, otherwise wrap around to the lowest requester
    assign next_idx = !upper_empty ? upper_idx :
                      !lower_empty ? lower_idx : rr_q;
    assign rr_d     = accept ? next_idx : rr_q;
  end else begin : gen_incr
    // plain rotation, the port after the winner gets the priority
    assign rr_d = !accept ? rr_q :
                  (idx_o == arb_pkg::port_idx_t'(NumIn - 1)) ? '0 : idx_o + 1'b1;
  end

  // flush returns the priority to port 0 and drops the lock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      req_q  <= '0;
    end else if (flush_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      req_q  <= '0;
    end else begin
      rr_q   <= rr_d;
      lock_q <= lock_d;
      req_q  <= req_d;
    end
  end

  ////////////////////
  // select tree
  ////////////////////

  // grant enters at the root, requests, data and index leave from it
  assign gnt_nodes[0] = gnt_i;
  assign req_o        = req_nodes[0];
  assign data_o       = data_nodes[0];
  assign idx_o        = idx_nodes[0];

  for (genvar lvl = 0; lvl < num_levels; lvl++) begin : gen_level
    for (genvar n = 0; n < 2**lvl; n++) begin : gen_node
      localparam int unsigned node  = 2**lvl - 1 + n;
      localparam int unsigned child = 2**(lvl+1) - 1 + 2*n;
      if (lvl == num_levels - 1) begin : gen_leaf
        if (2*n + 1 < NumIn) begin : gen_pair
          logic sel;
          // take the upper input if the lower is idle, or if both request and the priority bit says so
          assign sel = ~req_d[2*n] | (req_d[2*n+1] & rr_q[num_levels-1-lvl]);
          assign req_nodes[node]  = req_d[2*n] | req_d[2*n+1];
          assign idx_nodes[node]  = arb_pkg::port_idx_t'(sel);
          assign data_nodes[node] = sel ? data_i[2*n+1] : data_i[2*n];
          // a grant only ever reaches a port that is requesting
          assign gnt_o[2*n]       = gnt_nodes[node] & req_d[2*n]   & ~sel;
          assign gnt_o[2*n+1]     = gnt_nodes[node] & req_d[2*n+1] &  sel;
        end else if (2*n < NumIn) begin : gen_single
          // odd port count leaves one input without a partner
          assign req_nodes[node]  = req_d[2*n];
          assign idx_nodes[node]  = '0;
          assign data_nodes[node] = data_i[2*n];
          assign gnt_o[2*n]       = gnt_nodes[node] & req_d[2*n];
        end else begin : gen_pad
          assign req_nodes[node]  = 1'b0;
          assign idx_nodes[node]  = '0;
          assign data_nodes[node] = '0;
        end
      end else begin : gen_inner
        logic sel;
        // same rule one level up, steered by a more significant priority bit
        assign sel = ~req_nodes[child] | (req_nodes[child+1] & rr_q[num_levels-1-lvl]);
        assign req_nodes[node]    = req_nodes[child] | req_nodes[child+1];
        assign idx_nodes[node]    = sel ?
            arb_pkg::port_idx_t'({1'b1, idx_nodes[child+1][num_levels-lvl-2:0]}) :
            arb_pkg::port_idx_t'({1'b0, idx_nodes[child][num_levels-lvl-2:0]});
        assign data_nodes[node]   = sel ? data_nodes[child+1] : data_nodes[child];
        assign gnt_nodes[child]   = gnt_nodes[node] & ~sel;
        assign gnt_nodes[child+1] = gnt_nodes[node] &  sel;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/lzc.sv */
////////////////////
// trailing zero counter
// returns the lowest set bit position and flags an all zero input
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "arb_settings.svh"

module lzc #(
  parameter int unsigned WIDTH = `ARB_NUM_PORTS,
  localparam int unsigned CntW = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic [WIDTH-1:0] in_i,
  output logic [CntW-1:0]  cnt_o,
  output logic             empty_o
);

  // the input is padded up to a full binary tree, pad bits never win
  localparam int unsigned pad_w     = 2**CntW;
  localparam int unsigned num_nodes = pad_w - 1;

  logic [pad_w-1:0]                in_pad;
  logic [num_nodes-1:0]            sel_nodes;
  logic [num_nodes-1:0][CntW-1:0] cnt_nodes;

  assign in_pad = pad_w'(in_i);

  // each node reports whether its half holds a set bit and where the lowest one sits
  for (genvar lvl = 0; lvl < CntW; lvl++) begin : gen_level
    for (genvar n = 0; n < 2**lvl; n++) begin : gen_node
      localparam int unsigned node  = 2**lvl - 1 + n;
      localparam int unsigned child = 2**(lvl+1) - 1 + 2*n;
      if (lvl == CntW - 1) begin : gen_leaf
        // a leaf looks at two neighbouring input bits, the lower one takes precedence
        assign sel_nodes[node] = in_pad[2*n] | in_pad[2*n+1];
        assign cnt_nodes[node] = CntW'(~in_pad[2*n]);
      end else begin : gen_inner
        // the lower half wins whenever it has any set bit
        assign sel_nodes[node] = sel_nodes[child] | sel_nodes[child+1];
        assign cnt_nodes[node] = sel_nodes[child] ?
                                 CntW'({1'b0, cnt_nodes[child][CntW-lvl-2:0]}) :
                                 CntW'({1'b1, cnt_nodes[child+1][CntW-lvl-2:0]});
      end
    end
  end

  // the root carries the full count
  assign cnt_o   = cnt_nodes[0];
  assign empty_o = ~sel_nodes[0];

endmodule

`default_nettype wire

/* rtl/arb_pkg.sv */
////////////////////
// shared memory port arbiter
// request, response and port index types used across the design
////////////////////

`default_nettype none

`include "arb_settings.svh"

package arb_pkg;

  // index of one client port, also the width of the round robin priority
  typedef logic [$clog2(`ARB_NUM_PORTS)-1:0] port_idx_t;

  // one memory request as a client presents it
  typedef struct packed {
    // set for a write, clear for a read
    logic                   we;
    // word address inside the bank
    logic [`ARB_ADDR_W-1:0] addr;
    // data written when we is set
    logic [`ARB_DATA_W-1:0] wdata;
  } mem_req_t;

  // the answer of the bank, returned one cycle after the accept
  typedef struct packed {
    logic [`ARB_DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

/* include/arb_settings.svh */
////////////////////
// shared memory port arbiter
// compile time sizes and the arbitration mode switch
////////////////////

`ifndef ARB_SETTINGS_SVH
`define ARB_SETTINGS_SVH

// number of client ports that compete for the bank
`define ARB_NUM_PORTS 4

// word address width, the bank holds 2**ARB_ADDR_W words
`define ARB_ADDR_W 6

// width of one data word
`define ARB_DATA_W 16

// 1 selects the trailing zero fair update, 0 selects the plain increment
`define ARB_FAIR 1'b1

`endif
